// ==== Bender.yml ====
package:
  name: decompress_top

sources:
  - include_dirs:
      - common
    files:
      - common/decompress_pkg.sv
      - design/coeff_decompress.sv
      - design/decompress_ctrl.sv
      - piso/coeff_piso.sv
      - design/decompress_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - test/tb_decompress_top.sv

// ==== common/decompress_consts.svh ====
`ifndef DECOMPRESS_CONSTS_SVH
`define DECOMPRESS_CONSTS_SVH

// ML-KEM modulus and ring degree
`define MLKEM_Q 3329
`define MLKEM_N 256

// Coefficient width in the ring and in the destination memory word
`define Q_W 12
`define MEM_COEFF_W 24

// Coefficients handled per clock
`define COEFF_PER_CLK 4

// Memory address and source word widths
`define ADDR_W 15
`define SRC_W 64

// Repacking buffer, one source word plus the widest leftover
`define PISO_BUF_W 104

`endif

// ==== common/decompress_pkg.sv ====
`include "decompress_consts.svh"

package decompress_pkg;

    // Bits per coefficient in the packed source stream
    typedef enum logic [1:0] {
        MODE_D1  = 2'd0,
        MODE_D5  = 2'd1,
        MODE_D11 = 2'd2,
        MODE_D12 = 2'd3
    } decompress_mode_e;

    // Memory port operation
    typedef enum logic [1:0] {
        RW_IDLE  = 2'd0,
        RW_READ  = 2'd1,
        RW_WRITE = 2'd2
    } mem_rw_e;

    typedef struct packed {
        mem_rw_e                rw;
        logic [`ADDR_W-1:0]     addr;
    } mem_req_t;

    // Command is held stable by the requester while the engine runs
    typedef struct packed {
        decompress_mode_e       mode;
        logic [2:0]             num_poly;
        logic [`ADDR_W-1:0]     src_base;
        logic [`ADDR_W-1:0]     dest_base;
    } decompress_cmd_t;

    // Four coefficients per destination word, each zero padded to 24 bits
    typedef logic [`COEFF_PER_CLK-1:0][`MEM_COEFF_W-1:0] mem_wr_data_t;

    typedef logic [`SRC_W-1:0] src_word_t;

    // d for a given mode
    function automatic logic [3:0] mode_bits(decompress_mode_e mode);
        logic [3:0] d;
        unique case (mode)
            MODE_D1:  d = 4'd1;
            MODE_D5:  d = 4'd5;
            MODE_D11: d = 4'd11;
            default:  d = 4'd12;
        endcase
        return d;
    endfunction

endpackage

// ==== decompress_top.f ====
+incdir+common
common/decompress_pkg.sv
design/coeff_decompress.sv
design/decompress_ctrl.sv
piso/coeff_piso.sv
design/decompress_top.sv
test/tb_decompress_top.sv

// ==== design/coeff_decompress.sv ====
`timescale 1ns/1ps

`include "decompress_consts.svh"

module coeff_decompress (
    input  logic [`Q_W-1:0]                     coeff_i,
    input  decompress_pkg::decompress_mode_e    mode_i,
    output logic [`Q_W-1:0]                     coeff_o
);

    // 4095 * 3329 plus rounding fits in 24 bits
    localparam int PROD_W = 2 * `Q_W;

    logic [3:0]        d_bits;
    logic [PROD_W-1:0] product;
    logic [PROD_W-1:0] rounded;
    logic [PROD_W-1:0] scaled;

    assign d_bits = decompress_pkg::mode_bits(mode_i);

    // (x * q + 2^(d-1)) >> d
    always_comb begin
        product = PROD_W'(coeff_i) * PROD_W'(`MLKEM_Q);
        rounded = product + (PROD_W'(1) << (d_bits - 4'd1));
        scaled  = rounded >> d_bits;
    end

    // d = 12 is plain byte decoding, value goes through as is
    always_comb begin
        if (mode_i == decompress_pkg::MODE_D12) begin
            coeff_o = coeff_i;
        end else begin
            coeff_o = scaled[`Q_W-1:0];
        end
    end

endmodule

// ==== design/decompress_ctrl.sv ====
`timescale 1ns/1ps

`include "decompress_consts.svh"

module decompress_ctrl (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                zeroize_i,
    input  logic                enable_i,
    input  logic [2:0]          num_poly_i,
    input  logic [`ADDR_W-1:0]  dest_base_i,
    input  logic                wr_valid_i,
    output logic [`ADDR_W-1:0]  wr_addr_o,
    output logic                write_done_o
);

    // Up to 4 polynomials of 64 words each
    localparam int CNT_W = 9;

    logic [CNT_W-1:0] wr_cnt_q;
    logic [CNT_W-1:0] wr_total;
    logic             last_write;

    assign wr_total   = CNT_W'(num_poly_i) * CNT_W'(`MLKEM_N / `COEFF_PER_CLK);
    assign last_write = wr_valid_i && (wr_cnt_q + CNT_W'(1) == wr_total);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_addr_o    <= '0;
            wr_cnt_q     <= '0;
            write_done_o <= 1'b0;
        end else if (zeroize_i) begin
            wr_addr_o    <= '0;
            wr_cnt_q     <= '0;
            write_done_o <= 1'b0;
        end else if (enable_i) begin
            wr_addr_o    <= dest_base_i;
            wr_cnt_q     <= '0;
            write_done_o <= 1'b0;
        end else begin
            // done lands one cycle after the final write
            write_done_o <= last_write;
            if (wr_valid_i) begin
                wr_addr_o <= wr_addr_o + `ADDR_W'(1);
                wr_cnt_q  <= wr_cnt_q + CNT_W'(1);
            end
        end
    end

    // The piso must not produce more chunks than the command asks for
    a_no_extra_write : assert property (
        @(posedge clk) disable iff (!reset_n || zeroize_i)
        wr_valid_i |-> (wr_cnt_q < wr_total)
    );

endmodule

// ==== design/decompress_top.sv ====
`timescale 1ns/1ps

`include "decompress_consts.svh"

module decompress_top (
    input  logic                            clk,
    input  logic                            reset_n,
    input  logic                            zeroize_i,

    input  logic                            enable_i,
    input  decompress_pkg::decompress_cmd_t cmd_i,

    output logic                            rd_en_o,
    output logic [`ADDR_W-1:0]              rd_addr_o,
    input  decompress_pkg::src_word_t       rd_data_i,

    output decompress_pkg::mem_req_t        wr_req_o,
    output decompress_pkg::mem_wr_data_t    wr_data_o,

    output logic                            done_o
);

    logic                                   busy_q;
    logic                                   rd_valid_q;
    logic                                   read_done;
    logic [3:0]                             d_bits;
    logic [`ADDR_W-1:0]                     rd_words;
    logic                                   piso_hold;
    logic                                   piso_valid;
    logic [`COEFF_PER_CLK*`Q_W-1:0]         piso_data;
    logic [`COEFF_PER_CLK-1:0][`Q_W-1:0]    coeff_in;
    logic [`COEFF_PER_CLK-1:0][`Q_W-1:0]    coeff_out;
    logic [`ADDR_W-1:0]                     wr_addr;
    logic                                   write_done;

    // Busy from the enable strobe until the completion pulse
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            busy_q <= 1'b0;
        end else if (zeroize_i) begin
            busy_q <= 1'b0;
        end else if (enable_i) begin
            busy_q <= 1'b1;
        end else if (done_o) begin
            busy_q <= 1'b0;
        end
    end

    assign done_o = busy_q & write_done;

    // Source words per command: num_poly * 256 * d / 64
    assign d_bits   = decompress_pkg::mode_bits(cmd_i.mode);
    assign rd_words = `ADDR_W'(cmd_i.num_poly * d_bits * (`MLKEM_N / `SRC_W));

    assign read_done = (rd_addr_o == cmd_i.src_base + rd_words);
    assign rd_en_o   = busy_q & ~read_done & ~piso_hold;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_addr_o <= '0;
        end else if (zeroize_i) begin
            rd_addr_o <= '0;
        end else if (enable_i) begin
            rd_addr_o <= cmd_i.src_base;
        end else if (rd_en_o) begin
            rd_addr_o <= rd_addr_o + `ADDR_W'(1);
        end
    end

    // Read data shows up one cycle after the request
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_valid_q <= 1'b0;
        end else if (zeroize_i) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= rd_en_o;
        end
    end

    coeff_piso u_coeff_piso (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .mode_i    (cmd_i.mode),
        .valid_i   (rd_valid_q),
        .data_i    (rd_data_i),
        .hold_o    (piso_hold),
        .valid_o   (piso_valid),
        .data_o    (piso_data)
    );

    // Split the chunk into four d-bit fields, LSB first
    always_comb begin
        for (int i = 0; i < `COEFF_PER_CLK; i++) begin
            unique case (cmd_i.mode)
                decompress_pkg::MODE_D1:  coeff_in[i] = `Q_W'(piso_data[i*1 +: 1]);
                decompress_pkg::MODE_D5:  coeff_in[i] = `Q_W'(piso_data[i*5 +: 5]);
                decompress_pkg::MODE_D11: coeff_in[i] = `Q_W'(piso_data[i*11 +: 11]);
                default:                  coeff_in[i] = piso_data[i*12 +: 12];
            endcase
        end
    end

    for (genvar g = 0; g < `COEFF_PER_CLK; g++) begin : g_coeff
        coeff_decompress u_coeff_decompress (
            .coeff_i (coeff_in[g]),
            .mode_i  (cmd_i.mode),
            .coeff_o (coeff_out[g])
        );

        // Upper half of the memory field is always zero
        assign wr_data_o[g] = {{(`MEM_COEFF_W - `Q_W){1'b0}}, coeff_out[g]};
    end

    decompress_ctrl u_decompress_ctrl (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize_i    (zeroize_i),
        .enable_i     (enable_i),
        .num_poly_i   (cmd_i.num_poly),
        .dest_base_i  (cmd_i.dest_base),
        .wr_valid_i   (piso_valid),
        .wr_addr_o    (wr_addr),
        .write_done_o (write_done)
    );

    assign wr_req_o.rw   = piso_valid ? decompress_pkg::RW_WRITE : decompress_pkg::RW_IDLE;
    assign wr_req_o.addr = wr_addr;

    // Every read stays inside the source range of the current command
    a_read_in_range : assert property (
        @(posedge clk) disable iff (!reset_n || zeroize_i)
        rd_en_o |-> (`ADDR_W'(rd_addr_o - cmd_i.src_base) < rd_words)
    );

endmodule

// ==== piso/coeff_piso.sv ====
`timescale 1ns/1ps

`include "decompress_consts.svh"

module coeff_piso (
    input  logic                                clk,
    input  logic                                reset_n,
    input  logic                                zeroize_i,
    input  decompress_pkg::decompress_mode_e    mode_i,
    input  logic                                valid_i,
    input  decompress_pkg::src_word_t           data_i,
    output logic                                hold_o,
    output logic                                valid_o,
    output logic [`COEFF_PER_CLK*`Q_W-1:0]      data_o
);

    // Wide enough to show an overflow past the buffer width
    localparam int FILL_W = $clog2(`PISO_BUF_W + `SRC_W + 1);

    logic [`PISO_BUF_W-1:0] buf_q;
    logic [`PISO_BUF_W-1:0] buf_next;
    logic [FILL_W-1:0]      fill_q;
    logic [FILL_W-1:0]      fill_next;
    logic [FILL_W-1:0]      rate;
    logic [FILL_W-1:0]      base;
    logic [FILL_W-1:0]      residual;

    // Output chunk is 4*d bits: 4, 20, 44 or 48
    assign rate = FILL_W'(`COEFF_PER_CLK * decompress_pkg::mode_bits(mode_i));

    // Oldest bits sit at the bottom of the buffer
    assign valid_o = (fill_q >= rate);
    assign data_o  = buf_q[`COEFF_PER_CLK*`Q_W-1:0];

    always_comb begin
        // Drain first, then append the new word right above what is left
        if (valid_o) begin
            buf_next = buf_q >> rate;
            base     = fill_q - rate;
        end else begin
            buf_next = buf_q;
            base     = fill_q;
        end

        fill_next = base;
        if (valid_i) begin
            buf_next  = buf_next | (`PISO_BUF_W'(data_i) << base);
            fill_next = base + FILL_W'(`SRC_W);
        end
    end

    // A read issued now lands next cycle, after that cycle's own output
    always_comb begin
        if (fill_next >= rate) begin
            residual = fill_next - rate;
        end else begin
            residual = fill_next;
        end
        hold_o = (residual > FILL_W'(`PISO_BUF_W - `SRC_W));
    end

    // Bits above the fill level are kept at zero so appends can OR in
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            buf_q  <= '0;
            fill_q <= '0;
        end else if (zeroize_i) begin
            buf_q  <= '0;
            fill_q <= '0;
        end else begin
            buf_q  <= buf_next;
            fill_q <= fill_next;
        end
    end

    // The top's read throttling must keep the buffer from overflowing
    a_fill_in_range : assert property (
        @(posedge clk) disable iff (!reset_n)
        fill_q <= FILL_W'(`PISO_BUF_W)
    );

endmodule

// ==== test/tb_decompress_top.sv ====
`timescale 1ns/1ps

`include "decompress_consts.svh"

module tb_decompress_top;

    localparam int CLK_PERIOD  = 40;
    localparam int NUM_RANDOM  = 12;
    // Random commands, then the zeroized one and the one after it
    localparam int NUM_CMDS    = NUM_RANDOM + 2;
    localparam int CMD_LIMIT   = 4 * 300;
    localparam int WATCHDOG_NS = NUM_CMDS * 4 * 300 * CLK_PERIOD;
    localparam int ZEROIZE_AT  = 20;

    logic                            clk;
    logic                            reset_n;
    logic                            zeroize_i;
    logic                            enable_i;
    decompress_pkg::decompress_cmd_t cmd_i;
    logic                            rd_en_o;
    logic [`ADDR_W-1:0]              rd_addr_o;
    decompress_pkg::src_word_t       rd_data_i;
    decompress_pkg::mem_req_t        wr_req_o;
    decompress_pkg::mem_wr_data_t    wr_data_o;
    logic                            done_o;

    decompress_pkg::src_word_t       src_mem [0:(1 << `ADDR_W)-1];
    decompress_pkg::mem_req_t        exp_rd_q[$];
    decompress_pkg::mem_req_t        exp_wr_q[$];
    decompress_pkg::mem_wr_data_t    exp_data_q[$];
    logic [31:0]                     rng_state;
    logic                            rd_pend;
    logic [`ADDR_W-1:0]              rd_pend_addr;
    logic                            cmd_active;
    logic                            done_due;
    int                              wr_cnt;
    int                              exp_wr_total;
    int                              done_cnt;
    int                              err_value;
    int                              err_other;

    decompress_top u_decompress_top (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .enable_i  (enable_i),
        .cmd_i     (cmd_i),
        .rd_en_o   (rd_en_o),
        .rd_addr_o (rd_addr_o),
        .rd_data_i (rd_data_i),
        .wr_req_o  (wr_req_o),
        .wr_data_o (wr_data_o),
        .done_o    (done_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic next_rand(output logic [31:0] r);
        rng_state = xorshift32(rng_state);
        r = rng_state;
    endtask

    function automatic int bits_per_coeff(input decompress_pkg::decompress_mode_e mode);
        case (mode)
            decompress_pkg::MODE_D1:  return 1;
            decompress_pkg::MODE_D5:  return 5;
            decompress_pkg::MODE_D11: return 11;
            default:                  return 12;
        endcase
    endfunction

    // (x * q + 2^(d-1)) >> d, or the raw value for byte decoding
    function automatic logic [`Q_W-1:0] decompress_ref(input logic [`Q_W-1:0] x, input int d);
        int v;
        if (d == 12) begin
            v = int'(x);
        end else begin
            v = (int'(x) * `MLKEM_Q + (1 << (d - 1))) >> d;
        end
        return v[`Q_W-1:0];
    endfunction

    function automatic decompress_pkg::mem_req_t make_req(input decompress_pkg::mem_rw_e rw,
                                                           input logic [`ADDR_W-1:0] addr);
        decompress_pkg::mem_req_t r;
        r.rw   = rw;
        r.addr = addr;
        return r;
    endfunction

    task automatic check_req(input decompress_pkg::mem_req_t got,
                             input decompress_pkg::mem_req_t exp, input string what);
        if (got !== exp) begin
            err_value++;
            $display("FAIL %0t: %s request rw=%0d addr=%h, expected rw=%0d addr=%h",
                     $time, what, got.rw, got.addr, exp.rw, exp.addr);
        end
    endtask

    task automatic check_wr_data(input decompress_pkg::mem_wr_data_t got,
                                 input decompress_pkg::mem_wr_data_t exp);
        if (got !== exp) begin
            err_value++;
            $display("FAIL %0t: write data %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_done(input int got, input int exp);
        if (got != exp) begin
            err_value++;
            $display("FAIL %0t: %0d writes at done, expected %0d", $time, got, exp);
        end
    endtask

    // Reference unpacking, LSB first across consecutive source words
    task automatic build_model(input decompress_pkg::decompress_cmd_t cmd);
        int d;
        int n_coeff;
        int k;
        int i;
        int j;
        int b;
        logic [`Q_W-1:0] x;
        logic [`ADDR_W-1:0] a;
        decompress_pkg::mem_wr_data_t w;
        d       = bits_per_coeff(cmd.mode);
        n_coeff = cmd.num_poly * `MLKEM_N;
        w       = '0;
        exp_rd_q.delete();
        exp_wr_q.delete();
        exp_data_q.delete();
        for (i = 0; i < n_coeff * d / `SRC_W; i++) begin
            exp_rd_q.push_back(make_req(decompress_pkg::RW_READ, cmd.src_base + `ADDR_W'(i)));
        end
        for (j = 0; j < n_coeff; j++) begin
            x = '0;
            for (b = 0; b < d; b++) begin
                k    = j * d + b;
                a    = cmd.src_base + `ADDR_W'(k / `SRC_W);
                x[b] = src_mem[a][k % `SRC_W];
            end
            w[j % 4] = {{(`MEM_COEFF_W - `Q_W){1'b0}}, decompress_ref(x, d)};
            if (j % 4 == 3) begin
                exp_data_q.push_back(w);
                exp_wr_q.push_back(make_req(decompress_pkg::RW_WRITE,
                                            cmd.dest_base + `ADDR_W'(j / 4)));
            end
        end
        exp_wr_total = n_coeff / 4;
    endtask

    task automatic random_cmd(input int idx, output decompress_pkg::decompress_cmd_t cmd);
        logic [31:0] r;
        next_rand(r);
        // First four commands walk through every mode
        if (idx < 4) begin
            cmd.mode = decompress_pkg::decompress_mode_e'(idx[1:0]);
        end else begin
            cmd.mode = decompress_pkg::decompress_mode_e'(r[1:0]);
        end
        cmd.num_poly = 3'(r[3:2]) + 3'd1;
        cmd.src_base = r[18:4];
        next_rand(r);
        cmd.dest_base = r[14:0];
    endtask

    task automatic start_cmd(input decompress_pkg::decompress_cmd_t cmd);
        build_model(cmd);
        wr_cnt     = 0;
        done_due   = 1'b0;
        cmd_active = 1'b1;
        cmd_i      = cmd;
        enable_i   = 1'b1;
        @(negedge clk);
        enable_i   = 1'b0;
    endtask

    task automatic wait_done();
        int start;
        int waited;
        start  = done_cnt;
        waited = 0;
        while (done_cnt == start && waited < CMD_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (done_cnt == start) begin
            err_other++;
            $display("Command did not finish within %0d cycles at time %0t", CMD_LIMIT, $time);
        end
        repeat (4) @(negedge clk);
    endtask

    // Source memory answers one cycle after the request
    always @(posedge clk) begin
        rd_pend      <= rd_en_o;
        rd_pend_addr <= rd_addr_o;
    end

    always @(negedge clk) begin
        if (rd_pend) begin
            rd_data_i <= src_mem[rd_pend_addr];
        end
    end

    // Read, write and done monitor
    always @(posedge clk) begin
        if (reset_n) begin
            if (done_o && !done_due) begin
                err_other++;
                $display("done_o pulsed with no command finishing at time %0t", $time);
            end else if (done_o) begin
                done_cnt++;
                check_done(wr_cnt, exp_wr_total);
                if (exp_rd_q.size() != 0) begin
                    err_other++;
                    $display("%0d reads missing at done, time %0t", exp_rd_q.size(), $time);
                end
            end else if (done_due) begin
                err_other++;
                $display("done_o missing after the last write at time %0t", $time);
            end
            done_due = 1'b0;
            if (rd_en_o && exp_rd_q.size() == 0) begin
                err_other++;
                $display("Unexpected read of address %h at time %0t", rd_addr_o, $time);
            end else if (rd_en_o) begin
                check_req(make_req(decompress_pkg::RW_READ, rd_addr_o), exp_rd_q.pop_front(),
                          "read");
            end
            if (wr_req_o.rw != decompress_pkg::RW_IDLE) begin
                wr_cnt++;
                if (exp_wr_q.size() == 0) begin
                    err_other++;
                    $display("Unexpected write to address %h at time %0t", wr_req_o.addr, $time);
                end else begin
                    check_req(wr_req_o, exp_wr_q.pop_front(), "write");
                    check_wr_data(wr_data_o, exp_data_q.pop_front());
                    if (exp_wr_q.size() == 0 && cmd_active) begin
                        cmd_active = 1'b0;
                        done_due   = 1'b1;
                    end
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        err_other++;
        $display("Watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("Errors: %0d value, %0d other", err_value, err_other);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        decompress_pkg::decompress_cmd_t cmd;
        logic [31:0] hi;
        logic [31:0] lo;
        int a;
        int waited;
        clk        = 1'b0;
        reset_n    = 1'b0;
        zeroize_i  = 1'b0;
        enable_i   = 1'b0;
        cmd_i      = '0;
        rd_data_i  = '0;
        rd_pend    = 1'b0;
        cmd_active = 1'b0;
        done_due   = 1'b0;
        wr_cnt     = 0;
        done_cnt   = 0;
        err_value  = 0;
        err_other  = 0;
        rng_state  = 32'h3f2f_92fb;
        for (a = 0; a < (1 << `ADDR_W); a++) begin
            next_rand(hi);
            next_rand(lo);
            src_mem[a] = {hi, lo};
        end
        repeat (5) @(negedge clk);
        reset_n = 1'b1;
        // Idle engine after reset
        repeat (20) begin
            @(negedge clk);
            if (rd_en_o !== 1'b0 || done_o !== 1'b0) begin
                err_other++;
                $display("rd_en_o or done_o active while idle at time %0t", $time);
            end
            check_req(wr_req_o, make_req(decompress_pkg::RW_IDLE, '0), "idle");
        end
        for (int n = 0; n < NUM_RANDOM; n++) begin
            random_cmd(n, cmd);
            start_cmd(cmd);
            wait_done();
        end
        // Zeroize part way through a command
        random_cmd(NUM_RANDOM, cmd);
        start_cmd(cmd);
        waited = 0;
        while (wr_cnt < ZEROIZE_AT && waited < CMD_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (wr_cnt < ZEROIZE_AT) begin
            err_other++;
            $display("Only %0d writes seen before zeroize at time %0t", wr_cnt, $time);
        end
        zeroize_i = 1'b1;
        @(negedge clk);
        zeroize_i  = 1'b0;
        cmd_active = 1'b0;
        done_due   = 1'b0;
        exp_rd_q.delete();
        exp_wr_q.delete();
        exp_data_q.delete();
        // Monitor flags any read, write or done from here on
        repeat (10) @(negedge clk);
        random_cmd(NUM_RANDOM + 1, cmd);
        start_cmd(cmd);
        wait_done();
        $display("Errors: %0d value, %0d other", err_value, err_other);
        if (err_value + err_other == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
